// File: src/flow_mem_pkg.sv
/*
 * Flow memory package.
 * Shared widths, vector types and bundled records of the flow-state memory.
 */
package flow_mem_pkg;

    localparam int PIO_NBITS  = 32;  // Register bus width.
    localparam int FID_NBITS  = 16;
    localparam int TIME_NBITS = 16;
    localparam int KEY_NBITS  = 40;

    typedef logic [PIO_NBITS-1:0]  pio_addr_t;  // Byte address on the register bus.
    typedef logic [PIO_NBITS-1:0]  pio_data_t;
    typedef logic [FID_NBITS-1:0]  fid_t;       // Flow identifier from the lookup engine.
    typedef logic [TIME_NBITS-1:0] timestamp_t; // Real time or expiry time.
    typedef logic [KEY_NBITS-1:0]  flow_key_t;

    // One register access. rd and wr are single-cycle strobes.
    typedef struct packed {
        logic      rd;
        logic      wr;
        pio_addr_t addr;
        pio_data_t wdata;
    } pio_req_t;

    // One expiry-time update, also the entry type of the update FIFO.
    typedef struct packed {
        fid_t       fid;
        timestamp_t etime;
    } etime_update_t;

endpackage

// File: src/flow_ram_1r1w.sv
/*
 * Simple dual-port RAM with one write and one read port.
 * Writes land at the clock edge; the read address is registered there too.
 */
module flow_ram_1r1w #(
    parameter int DATA_NBITS = 8,
    parameter int ADDR_NBITS = 4
) (
    input  logic                  clk,
    input  logic                  wr,
    input  logic [ADDR_NBITS-1:0] waddr,
    input  logic [ADDR_NBITS-1:0] raddr,
    input  logic [DATA_NBITS-1:0] wdata,
    output logic [DATA_NBITS-1:0] rdata
);

    logic [DATA_NBITS-1:0] mem [2**ADDR_NBITS];
    logic [ADDR_NBITS-1:0] raddr_q;

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[waddr] <= wdata;
        end
        raddr_q <= raddr;  // Read data follows the latched address.
    end

    // A write and a read latched on the same edge return the new data.
    assign rdata = mem[raddr_q];

endmodule

// File: src/flow_bucket_bank.sv
/*
 * One bank of the flow hash table.
 * The lookup engine has priority; a latched register access runs on an idle cycle.
 */
module flow_bucket_bank #(
    parameter int DEPTH_NBITS  = 5,
    parameter int BUCKET_NBITS = 24
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  flow_mem_pkg::pio_req_t    pio_req,
    input  logic                      reg_ms,
    output logic                      reg_ack,
    output flow_mem_pkg::pio_data_t   reg_rdata,
    input  logic                      app_rd,
    input  logic                      app_wr,
    input  logic [DEPTH_NBITS-1:0]    app_raddr,
    input  logic [DEPTH_NBITS-1:0]    app_waddr,
    input  logic [BUCKET_NBITS-1:0]   app_wdata,
    output logic                      app_ack,
    output logic [BUCKET_NBITS-1:0]   app_rdata
);

    logic                    pend_valid;
    logic                    pend_wr;    // Pending access is a write when set.
    logic [DEPTH_NBITS-1:0]  pend_idx;
    logic [BUCKET_NBITS-1:0] pend_data;
    logic                    reg_go;
    logic                    reg_new;
    logic                    ram_wr;
    logic [DEPTH_NBITS-1:0]  ram_waddr;
    logic [DEPTH_NBITS-1:0]  ram_raddr;
    logic [BUCKET_NBITS-1:0] ram_wdata;
    logic [BUCKET_NBITS-1:0] ram_rdata;

    assign reg_new = reg_ms & (pio_req.rd | pio_req.wr);

    // The register access only runs when the lookup engine leaves the RAM alone.
    assign reg_go = pend_valid & ~app_rd & ~app_wr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pend_valid <= 1'b0;
            reg_ack    <= 1'b0;
            app_ack    <= 1'b0;
        end else begin
            if (reg_new) begin
                pend_valid <= 1'b1;
            end else if (reg_go) begin
                pend_valid <= 1'b0;
            end
            reg_ack <= reg_go;
            app_ack <= app_rd;
        end
    end

    // Index is the low part of the quadword address.
    always_ff @(posedge clk) begin
        if (reg_new) begin
            pend_wr   <= pio_req.wr;
            pend_idx  <= pio_req.addr[DEPTH_NBITS+2:3];
            pend_data <= pio_req.wdata[BUCKET_NBITS-1:0];
        end
    end

    assign ram_wr    = app_wr | (reg_go & pend_wr);
    assign ram_waddr = app_wr ? app_waddr : pend_idx;
    assign ram_wdata = app_wr ? app_wdata : pend_data;
    assign ram_raddr = app_rd ? app_raddr : pend_idx;

    flow_ram_1r1w #(
        .DATA_NBITS(BUCKET_NBITS),
        .ADDR_NBITS(DEPTH_NBITS)
    ) u_ram (
        .clk  (clk),
        .wr   (ram_wr),
        .waddr(ram_waddr),
        .raddr(ram_raddr),
        .wdata(ram_wdata),
        .rdata(ram_rdata)
    );

    assign app_rdata = ram_rdata;
    assign reg_rdata = flow_mem_pkg::pio_data_t'(ram_rdata);  // Zero-extended bucket.

    // A selected request must be either a read or a write.
    a_reg_rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n)
        reg_ms |-> !(pio_req.rd && pio_req.wr));

endmodule

// File: src/flow_etime_fifo.sv
/*
 * Two-entry FIFO for expiry-time updates.
 * The head entry is visible without a read latency.
 */
module flow_etime_fifo (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        push,
    input  flow_mem_pkg::etime_update_t push_data,
    input  logic                        pop,
    output logic                        empty,
    output flow_mem_pkg::etime_update_t head
);

    flow_mem_pkg::etime_update_t entry [2];
    logic       wptr;
    logic       rptr;
    logic [1:0] count;  // 0, 1 or 2 entries held.
    logic       full;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wptr  <= 1'b0;
            rptr  <= 1'b0;
            count <= 2'd0;
        end else begin
            if (push) begin
                wptr <= ~wptr;
            end
            if (pop) begin
                rptr <= ~rptr;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entry[wptr] <= push_data;
        end
    end

    assign empty = (count == 2'd0);
    assign full  = (count == 2'd2);
    assign head  = entry[rptr];

    // Pushing into a full queue is only safe when the head leaves in the same cycle.
    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        push && full |-> pop);

    a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
        pop |-> !empty);

endmodule

// File: src/flow_mem.sv
/*
 * Flow-state memory of the packet classifier.
 * Two hash-table banks behind one register window, plus the flow key and
 * expiry stores, which are swept to zero after reset.
 */
module flow_mem #(
    parameter int DEPTH_NBITS       = 5,
    parameter int BUCKET_NBITS      = 24,
    parameter int VALUE_DEPTH_NBITS = 6
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  flow_mem_pkg::pio_req_t        pio_req,
    input  logic                          reg_ms,
    output logic                          reg_ack,
    output flow_mem_pkg::pio_data_t       reg_rdata,
    input  logic                          bucket0_rd,
    input  logic                          bucket0_wr,
    input  logic [DEPTH_NBITS-1:0]        bucket0_raddr,
    input  logic [DEPTH_NBITS-1:0]        bucket0_waddr,
    input  logic [BUCKET_NBITS-1:0]       bucket0_wdata,
    output logic                          bucket0_ack,
    output logic [BUCKET_NBITS-1:0]       bucket0_rdata,
    input  logic                          bucket1_rd,
    input  logic                          bucket1_wr,
    input  logic [DEPTH_NBITS-1:0]        bucket1_raddr,
    input  logic [DEPTH_NBITS-1:0]        bucket1_waddr,
    input  logic [BUCKET_NBITS-1:0]       bucket1_wdata,
    output logic                          bucket1_ack,
    output logic [BUCKET_NBITS-1:0]       bucket1_rdata,
    input  logic                          key_rd,
    input  logic [VALUE_DEPTH_NBITS-1:0]  key_raddr,
    input  logic                          key_wr,
    input  logic [VALUE_DEPTH_NBITS-1:0]  key_waddr,
    input  flow_mem_pkg::flow_key_t       key_wdata,
    output logic                          key_ack,
    output flow_mem_pkg::flow_key_t       key_rdata,
    input  logic                          etime_rd,
    input  logic [VALUE_DEPTH_NBITS-1:0]  etime_raddr,
    output logic                          etime_ack,
    output flow_mem_pkg::timestamp_t      etime_rdata,
    input  flow_mem_pkg::timestamp_t      current_time,
    input  logic                          hit_valid,
    input  flow_mem_pkg::fid_t            hit_fid,
    input  logic                          upd_valid,
    input  flow_mem_pkg::etime_update_t   upd
);

    logic                           bank_sel;  // Set selects bank 1.
    logic                           reg_ack0;
    logic                           reg_ack1;
    flow_mem_pkg::pio_data_t        reg_rdata0;
    flow_mem_pkg::pio_data_t        reg_rdata1;

    logic                           sweep_active;
    logic [VALUE_DEPTH_NBITS-1:0]   sweep_addr;

    logic                           key_wr_q;
    logic [VALUE_DEPTH_NBITS-1:0]   key_waddr_q;
    flow_mem_pkg::flow_key_t        key_wdata_q;

    logic                           hit_valid_q;
    flow_mem_pkg::fid_t             hit_fid_q;
    flow_mem_pkg::timestamp_t       time_q;
    logic                           upd_valid_q;
    flow_mem_pkg::etime_update_t    upd_q;

    logic                           fifo_empty;
    logic                           fifo_pop;
    flow_mem_pkg::etime_update_t    fifo_head;

    logic                           etime_wr_q;
    logic [VALUE_DEPTH_NBITS-1:0]   etime_waddr_q;
    flow_mem_pkg::timestamp_t       etime_wdata_q;

    // Bit DEPTH_NBITS of the quadword address picks the bank.
    assign bank_sel = pio_req.addr[DEPTH_NBITS+3];

    flow_bucket_bank #(
        .DEPTH_NBITS (DEPTH_NBITS),
        .BUCKET_NBITS(BUCKET_NBITS)
    ) u_bank0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .pio_req  (pio_req),
        .reg_ms   (reg_ms & ~bank_sel),
        .reg_ack  (reg_ack0),
        .reg_rdata(reg_rdata0),
        .app_rd   (bucket0_rd),
        .app_wr   (bucket0_wr),
        .app_raddr(bucket0_raddr),
        .app_waddr(bucket0_waddr),
        .app_wdata(bucket0_wdata),
        .app_ack  (bucket0_ack),
        .app_rdata(bucket0_rdata)
    );

    flow_bucket_bank #(
        .DEPTH_NBITS (DEPTH_NBITS),
        .BUCKET_NBITS(BUCKET_NBITS)
    ) u_bank1 (
        .clk      (clk),
        .arst_n   (arst_n),
        .pio_req  (pio_req),
        .reg_ms   (reg_ms & bank_sel),
        .reg_ack  (reg_ack1),
        .reg_rdata(reg_rdata1),
        .app_rd   (bucket1_rd),
        .app_wr   (bucket1_wr),
        .app_raddr(bucket1_raddr),
        .app_waddr(bucket1_waddr),
        .app_wdata(bucket1_wdata),
        .app_ack  (bucket1_ack),
        .app_rdata(bucket1_rdata)
    );

    // The address is held until the ack, so the same bit steers the response.
    assign reg_ack   = bank_sel ? reg_ack1 : reg_ack0;
    assign reg_rdata = bank_sel ? reg_rdata1 : reg_rdata0;

    // The expiry write slot goes to a hit first, otherwise to a queued update.
    assign fifo_pop = ~hit_valid_q & ~fifo_empty;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sweep_active <= 1'b1;  // Zeroing starts right after reset.
            sweep_addr   <= '0;
            key_wr_q     <= 1'b0;
            hit_valid_q  <= 1'b0;
            upd_valid_q  <= 1'b0;
            etime_wr_q   <= 1'b0;
            key_ack      <= 1'b0;
            etime_ack    <= 1'b0;
        end else begin
            if (sweep_active) begin
                sweep_addr <= sweep_addr + 1'b1;
                if (&sweep_addr) begin
                    sweep_active <= 1'b0;  // Last address written this cycle.
                end
            end
            key_wr_q    <= key_wr;
            hit_valid_q <= hit_valid;
            upd_valid_q <= upd_valid;
            etime_wr_q  <= hit_valid_q | ~fifo_empty;
            key_ack     <= key_rd;
            etime_ack   <= etime_rd;
        end
    end

    always_ff @(posedge clk) begin
        key_waddr_q <= key_waddr;
        key_wdata_q <= key_wdata;
        hit_fid_q   <= hit_fid;
        time_q      <= current_time;
        upd_q       <= upd;
        if (hit_valid_q) begin
            etime_waddr_q <= hit_fid_q[VALUE_DEPTH_NBITS-1:0];
            etime_wdata_q <= time_q;
        end else begin
            etime_waddr_q <= fifo_head.fid[VALUE_DEPTH_NBITS-1:0];
            etime_wdata_q <= fifo_head.etime;
        end
    end

    flow_etime_fifo u_upd_fifo (
        .clk      (clk),
        .arst_n   (arst_n),
        .push     (upd_valid_q),
        .push_data(upd_q),
        .pop      (fifo_pop),
        .empty    (fifo_empty),
        .head     (fifo_head)
    );

    // The sweep owns both write ports until it finishes.
    flow_ram_1r1w #(
        .DATA_NBITS(flow_mem_pkg::KEY_NBITS),
        .ADDR_NBITS(VALUE_DEPTH_NBITS)
    ) u_key_ram (
        .clk  (clk),
        .wr   (sweep_active | key_wr_q),
        .waddr(sweep_active ? sweep_addr : key_waddr_q),
        .raddr(key_raddr),
        .wdata(sweep_active ? '0 : key_wdata_q),
        .rdata(key_rdata)
    );

    flow_ram_1r1w #(
        .DATA_NBITS(flow_mem_pkg::TIME_NBITS),
        .ADDR_NBITS(VALUE_DEPTH_NBITS)
    ) u_etime_ram (
        .clk  (clk),
        .wr   (sweep_active | etime_wr_q),
        .waddr(sweep_active ? sweep_addr : etime_waddr_q),
        .raddr(etime_raddr),
        .wdata(sweep_active ? '0 : etime_wdata_q),
        .rdata(etime_rdata)
    );

    // Store traffic during the sweep would be silently dropped.
    a_no_write_in_sweep: assert property (@(posedge clk) disable iff (!arst_n)
        sweep_active && (sweep_addr != '0) |-> !key_wr_q && !etime_wr_q);

endmodule

// File: testbench/tb_flow_mem.sv
/*
 * Testbench of the flow-state memory.
 * Directed tests of the reset sweep, both bucket banks, the register window
 * and the key and expiry stores.
 */
module tb_flow_mem;

    localparam int DEPTH_NBITS       = 5;
    localparam int BUCKET_NBITS      = 24;
    localparam int VALUE_DEPTH_NBITS = 6;
    localparam int BUCKETS           = 2**DEPTH_NBITS;
    localparam int VALUES            = 2**VALUE_DEPTH_NBITS;
    localparam int BURST_LEN         = 6;     // Back-to-back application reads.
    localparam int MAX_CYCLES        = 3000;  // Several times the roughly 400 cycles of all tests.

    logic                                    clk = 1'b0;
    logic                                    arst_n;
    flow_mem_pkg::pio_req_t                  pio_req;
    logic                                    reg_ms;
    logic                                    reg_ack;
    flow_mem_pkg::pio_data_t                 reg_rdata;
    logic [1:0]                              app_rd;  // Index 1 drives bank 1.
    logic [1:0]                              app_wr;
    logic [1:0][DEPTH_NBITS-1:0]             app_raddr;
    logic [1:0][DEPTH_NBITS-1:0]             app_waddr;
    logic [1:0][BUCKET_NBITS-1:0]            app_wdata;
    logic [1:0]                              app_ack;
    logic [1:0][BUCKET_NBITS-1:0]            app_rdata;
    logic                                    key_rd;
    logic [VALUE_DEPTH_NBITS-1:0]            key_raddr;
    logic                                    key_wr;
    logic [VALUE_DEPTH_NBITS-1:0]            key_waddr;
    flow_mem_pkg::flow_key_t                 key_wdata;
    logic                                    key_ack;
    flow_mem_pkg::flow_key_t                 key_rdata;
    logic                                    etime_rd;
    logic [VALUE_DEPTH_NBITS-1:0]            etime_raddr;
    logic                                    etime_ack;
    flow_mem_pkg::timestamp_t                etime_rdata;
    flow_mem_pkg::timestamp_t                current_time;
    logic                                    hit_valid;
    flow_mem_pkg::fid_t                      hit_fid;
    logic                                    upd_valid;
    flow_mem_pkg::etime_update_t             upd;
    int                                      cycle_count = 0;

    logic [BUCKET_NBITS-1:0]                 bank_model [2][BUCKETS];
    flow_mem_pkg::flow_key_t                 key_model [VALUES];
    flow_mem_pkg::timestamp_t                etime_model [VALUES];

    flow_mem u_flow_mem (
        .clk          (clk),
        .arst_n       (arst_n),
        .pio_req      (pio_req),
        .reg_ms       (reg_ms),
        .reg_ack      (reg_ack),
        .reg_rdata    (reg_rdata),
        .bucket0_rd   (app_rd[0]),
        .bucket0_wr   (app_wr[0]),
        .bucket0_raddr(app_raddr[0]),
        .bucket0_waddr(app_waddr[0]),
        .bucket0_wdata(app_wdata[0]),
        .bucket0_ack  (app_ack[0]),
        .bucket0_rdata(app_rdata[0]),
        .bucket1_rd   (app_rd[1]),
        .bucket1_wr   (app_wr[1]),
        .bucket1_raddr(app_raddr[1]),
        .bucket1_waddr(app_waddr[1]),
        .bucket1_wdata(app_wdata[1]),
        .bucket1_ack  (app_ack[1]),
        .bucket1_rdata(app_rdata[1]),
        .key_rd       (key_rd),
        .key_raddr    (key_raddr),
        .key_wr       (key_wr),
        .key_waddr    (key_waddr),
        .key_wdata    (key_wdata),
        .key_ack      (key_ack),
        .key_rdata    (key_rdata),
        .etime_rd     (etime_rd),
        .etime_raddr  (etime_raddr),
        .etime_ack    (etime_ack),
        .etime_rdata  (etime_rdata),
        .current_time (current_time),
        .hit_valid    (hit_valid),
        .hit_fid      (hit_fid),
        .upd_valid    (upd_valid),
        .upd          (upd)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("** Error: the run timed out after %0d cycles", cycle_count);
            $display("Finished with errors");
            $fatal(1);
        end
    end

    // Inputs change a little after the edge, outputs are sampled at the same point.
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic app_write(input int bank, input int idx, input logic [BUCKET_NBITS-1:0] data);
        app_wr[bank]    = 1'b1;
        app_waddr[bank] = DEPTH_NBITS'(idx);
        app_wdata[bank] = data;
        next_cycle();
        app_wr[bank]          = 1'b0;
        bank_model[bank][idx] = data;
    endtask

    task automatic app_read_check(input string name, input int bank, input int idx);
        app_rd[bank]    = 1'b1;
        app_raddr[bank] = DEPTH_NBITS'(idx);
        next_cycle();
        app_rd[bank] = 1'b0;
        check_value({name, "_ack"}, 64'd1, app_ack[bank]);
        check_value(name, bank_model[bank][idx], app_rdata[bank]);
    endtask

    // Byte address of a bucket; the bank bit sits just above the quadword index.
    function automatic flow_mem_pkg::pio_addr_t window_addr(input int bank, input int idx);
        return flow_mem_pkg::pio_addr_t'(((bank * BUCKETS) + idx) * 8);
    endfunction

    // Issues one strobe and holds the address until reg_ack.
    task automatic reg_access(input logic wr, input int bank, input int idx,
                              input flow_mem_pkg::pio_data_t wdata,
                              output flow_mem_pkg::pio_data_t rdata);
        pio_req.rd    = ~wr;
        pio_req.wr    = wr;
        pio_req.addr  = window_addr(bank, idx);
        pio_req.wdata = wdata;
        reg_ms        = 1'b1;
        next_cycle();
        reg_ms     = 1'b0;
        pio_req.rd = 1'b0;
        pio_req.wr = 1'b0;
        while (reg_ack !== 1'b1) begin
            next_cycle();
        end
        rdata = reg_rdata;
        if (wr) begin
            bank_model[bank][idx] = wdata[BUCKET_NBITS-1:0];  // Upper bits are dropped.
        end
    endtask

    task automatic etime_read_check(input string name, input int idx);
        etime_rd    = 1'b1;
        etime_raddr = VALUE_DEPTH_NBITS'(idx);
        next_cycle();
        etime_rd = 1'b0;
        check_value({name, "_ack"}, 64'd1, etime_ack);
        check_value(name, etime_model[idx], etime_rdata);
    endtask

    // One cycle of hit and update strobes. Only the low fid bits pick the entry.
    task automatic expiry_cycle(input logic hit, input int hit_id,
                                input flow_mem_pkg::timestamp_t stamp,
                                input logic update, input int upd_id,
                                input flow_mem_pkg::timestamp_t etime);
        hit_valid    = hit;
        hit_fid      = flow_mem_pkg::fid_t'(hit_id);
        current_time = stamp;
        upd_valid    = update;
        upd.fid      = flow_mem_pkg::fid_t'(upd_id);
        upd.etime    = etime;
        if (hit) begin
            etime_model[hit_id % VALUES] = stamp;
        end
        if (update) begin
            etime_model[upd_id % VALUES] = etime;
        end
        next_cycle();
        hit_valid = 1'b0;
        upd_valid = 1'b0;
    endtask

    task automatic sweep_zeroes();
        repeat (VALUES + 2) next_cycle();
        for (int idx = 0; idx < VALUES; idx++) begin
            key_rd      = 1'b1;
            key_raddr   = VALUE_DEPTH_NBITS'(idx);
            etime_rd    = 1'b1;
            etime_raddr = VALUE_DEPTH_NBITS'(idx);
            next_cycle();
            key_rd   = 1'b0;
            etime_rd = 1'b0;
            check_value("sweep_key_ack", 64'd1, key_ack);
            check_value("sweep_key", 64'd0, key_rdata);
            check_value("sweep_etime_ack", 64'd1, etime_ack);
            check_value("sweep_etime", 64'd0, etime_rdata);
        end
    endtask

    task automatic bucket_roundtrip();
        for (int bank = 0; bank < 2; bank++) begin
            for (int idx = 0; idx < BUCKETS; idx++) begin
                app_write(bank, idx, BUCKET_NBITS'($urandom()));
            end
        end
        for (int bank = 0; bank < 2; bank++) begin
            for (int idx = 0; idx < BUCKETS; idx++) begin
                app_read_check("bucket_roundtrip", bank, idx);
            end
        end
    endtask

    task automatic register_window();
        flow_mem_pkg::pio_data_t rdata;
        int                      idx;
        for (int bank = 0; bank < 2; bank++) begin
            idx = int'($urandom_range(BUCKETS - 1));
            reg_access(1'b1, bank, idx, $urandom(), rdata);
            app_read_check("reg_write_app_read", bank, idx);
            idx = int'($urandom_range(BUCKETS - 1));
            app_write(bank, idx, BUCKET_NBITS'($urandom()));
            reg_access(1'b0, bank, idx, '0, rdata);
            check_value("app_write_reg_read", 64'(bank_model[bank][idx]), rdata);
        end
    endtask

    task automatic register_backpressure();
        pio_req.rd    = 1'b1;
        pio_req.wr    = 1'b0;
        pio_req.addr  = window_addr(0, BUCKETS - 1);
        pio_req.wdata = '0;
        reg_ms        = 1'b1;
        app_rd[0]     = 1'b1;
        for (int i = 0; i < BURST_LEN; i++) begin
            app_raddr[0] = DEPTH_NBITS'(i);
            next_cycle();
            reg_ms     = 1'b0;
            pio_req.rd = 1'b0;
            check_value("burst_app_ack", 64'd1, app_ack[0]);
            check_value("burst_app_rdata", bank_model[0][i], app_rdata[0]);
            check_value("burst_reg_ack", 64'd0, reg_ack);
        end
        app_rd[0] = 1'b0;  // This idle cycle runs the pending read.
        next_cycle();
        check_value("burst_reg_ack_end", 64'd1, reg_ack);
        check_value("burst_reg_rdata", 64'(bank_model[0][BUCKETS-1]), reg_rdata);
        next_cycle();
        check_value("burst_reg_ack_pulse", 64'd0, reg_ack);
    endtask

    task automatic key_roundtrip();
        int idx;
        for (int n = 0; n < 16; n++) begin
            idx            = int'($urandom_range(VALUES - 1));
            key_wr         = 1'b1;
            key_waddr      = VALUE_DEPTH_NBITS'(idx);
            key_wdata      = flow_mem_pkg::flow_key_t'({$urandom(), $urandom()});
            key_model[idx] = key_wdata;
            next_cycle();
        end
        key_wr = 1'b0;
        next_cycle();  // Reads start two cycles after the last write strobe.
        for (int i = 0; i < VALUES; i++) begin
            key_rd    = 1'b1;
            key_raddr = VALUE_DEPTH_NBITS'(i);
            next_cycle();
            key_rd = 1'b0;
            check_value("key_ack", 64'd1, key_ack);
            check_value("key_roundtrip", key_model[i], key_rdata);
        end
    endtask

    task automatic expiry_writers();
        expiry_cycle(1'b1, 16'h0105, flow_mem_pkg::timestamp_t'($urandom()), 1'b0, 0, '0);
        repeat (3) next_cycle();
        etime_read_check("hit_stamp", 5);
        expiry_cycle(1'b0, 0, '0, 1'b1, 16'h2209, flow_mem_pkg::timestamp_t'($urandom()));
        repeat (3) next_cycle();
        etime_read_check("update_etime", 9);
    endtask

    // Hits fill every slot, so both updates wait in the FIFO.
    task automatic hit_priority();
        for (int n = 0; n < 6; n++) begin
            expiry_cycle(1'b1, 16'h0310 + n, flow_mem_pkg::timestamp_t'($urandom()),
                         (n == 1) || (n == 2), 16'h0420 + n,
                         flow_mem_pkg::timestamp_t'($urandom()));
        end
        repeat (6) next_cycle();
        for (int n = 0; n < 6; n++) begin
            etime_read_check("hit_priority", 16 + n);
        end
        etime_read_check("queued_update", 33);
        etime_read_check("queued_update", 34);
    endtask

    initial begin
        void'($urandom(31947));
        arst_n       = 1'b0;
        pio_req      = '0;
        reg_ms       = 1'b0;
        app_rd       = '0;
        app_wr       = '0;
        app_raddr    = '0;
        app_waddr    = '0;
        app_wdata    = '0;
        key_rd       = 1'b0;
        key_raddr    = '0;
        key_wr       = 1'b0;
        key_waddr    = '0;
        key_wdata    = '0;
        etime_rd     = 1'b0;
        etime_raddr  = '0;
        current_time = '0;
        hit_valid    = 1'b0;
        hit_fid      = '0;
        upd_valid    = 1'b0;
        upd          = '0;
        for (int i = 0; i < VALUES; i++) begin
            key_model[i]   = '0;
            etime_model[i] = '0;
        end
        repeat (4) @(posedge clk);
        #2;
        arst_n = 1'b1;
        sweep_zeroes();
        bucket_roundtrip();
        register_window();
        register_backpressure();
        key_roundtrip();
        expiry_writers();
        hit_priority();
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: filelist.f
src/flow_mem_pkg.sv
src/flow_ram_1r1w.sv
src/flow_bucket_bank.sv
src/flow_etime_fifo.sv
src/flow_mem.sv
testbench/tb_flow_mem.sv

// File: Bender.yml
package:
  name: flow_mem

sources:
  - src/flow_mem_pkg.sv
  - src/flow_ram_1r1w.sv
  - src/flow_bucket_bank.sv
  - src/flow_etime_fifo.sv
  - src/flow_mem.sv
  - target: test
    files:
      - testbench/tb_flow_mem.sv
